// File: verification/issue_input.txt
# w addr data exp_pslverr | r addr exp_prdata | n cycles exp_issue_valid
# i exp_dst exp_src1 exp_src2 issue_ready   (all fields hex)
n 2 0
r 8 00000000
w 0 00087081 0
w 0 0008d144 0
i 01 02 03 1
i 04 05 06 1
n 2 0
w 0 000982ca 0
w 0 0009f38d 0
w 0 000a5450 0
i 0d 0e 0f 1
w 4 0000000b 0
i 0a 0b 0c 1
i 10 11 12 1
w 0 000ab513 0
i 13 14 15 0
n 3 1
w 0 000b15d6 0
i 13 14 15 0
i 13 14 15 1
i 16 17 18 1
n 2 0
r 8 00000000
w 0 000c4860 0
w 0 000c4860 0
w 0 000c4860 0
w 0 000c4860 0
w 0 000c4860 0
w 0 000c4860 0
w 0 000c4860 0
w 0 000c4860 0
r 8 00000108
w 0 000fffff 1
n 2 0
w c 00000000 1
r c 00000000
r 4 00000000
r 8 00000108

// File: verilog.f
src/iq_pkg.sv
src/iq_ctrl_if.sv
src/iq_apb_regs.sv
src/age_matrix_select.sv
src/iq_entry_store.sv
src/issue_queue_top.sv
verification/tb_issue_queue.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_issue_queue
RTL_TOP   ?= issue_queue_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;

  localparam int DEPTH = 8;
  localparam int tag_w = 6;
  localparam logic [3:0] addr_status = 4'h8;   // only readable address
  localparam string stim_file = "verification/issue_input.txt";

  logic             clk;
  logic             rst;
  logic             psel;
  logic             penable;
  logic             pwrite;
  logic [3:0]       paddr;
  logic [31:0]      pwdata;
  logic [31:0]      prdata;
  logic             pready;
  logic             pslverr;
  logic             issue_valid;
  logic             issue_ready;
  logic [tag_w-1:0] issue_dst;
  logic [tag_w-1:0] issue_src1;
  logic [tag_w-1:0] issue_src2;

  int cycles = 0;
  int limit  = 100;   // raised once the records are counted

  issue_queue_top #(
    .DEPTH(DEPTH)
  ) i_dut (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue_dst  (issue_dst),
    .issue_src1 (issue_src1),
    .issue_src2 (issue_src2)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort(input string why);
    $display("CHECKS FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) abort("timeout, the test did not finish within the cycle limit");
  end

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, input logic exp_err);
    psel    = 1'b1;   // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk); #2;
    penable = 1'b1;
    #10;
    check(32'(pready), 32'd1, "pready");
    check(32'(pslverr), 32'(exp_err), "pslverr on write");
    @(posedge clk); #2;   // transfer completed at this edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, input logic [31:0] exp_data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk); #2;
    penable = 1'b1;
    #10;
    check(32'(pslverr), 32'(addr != addr_status), "pslverr on read");
    if (addr == addr_status) check(prdata, exp_data, "status read");
    @(posedge clk); #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // waits for a candidate, then checks it and lets it go if ready is set
  task automatic expect_issue(input logic [tag_w-1:0] dst, input logic [tag_w-1:0] src1,
                              input logic [tag_w-1:0] src2, input logic ready);
    issue_ready = ready;
    while (!issue_valid) begin
      @(posedge clk); #2;
    end
    check(32'(issue_dst), 32'(dst), "issue_dst");
    check(32'(issue_src1), 32'(src1), "issue_src1");
    check(32'(issue_src2), 32'(src2), "issue_src2");
    @(posedge clk); #2;
    issue_ready = 1'b0;
  endtask

  task automatic idle(input int n, input logic exp_valid);
    repeat (n) begin
      check(32'(issue_valid), 32'(exp_valid), "issue_valid while idle");
      @(posedge clk); #2;
    end
  endtask

  task automatic count_records(output int n);
    int             fd;
    logic [7:0]     op;
    logic [8*160-1:0] rest;
    n  = 0;
    fd = $fopen(stim_file, "r");
    if (fd == 0) abort("cannot open the stimulus file");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op != "#") n++;
      void'($fgets(rest, fd));
    end
    $fclose(fd);
  endtask

  initial begin
    int               fd;
    int               nrec;
    int               r;
    logic [7:0]       op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [31:0]      d;
    logic [8*160-1:0] rest;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    issue_ready = 1'b0;
    count_records(nrec);
    limit = nrec * 8 + 100;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    fd  = $fopen(stim_file, "r");
    if (fd == 0) abort("cannot open the stimulus file");
    while ($fscanf(fd, "%s", op) == 1) begin
      if (op == "#") begin
        void'($fgets(rest, fd));
      end else if (op == "w") begin
        r = $fscanf(fd, "%h %h %h", a, b, c);
        if (r != 3) abort("malformed write record in the stimulus file");
        apb_write(a[3:0], b, c[0]);
      end else if (op == "r") begin
        r = $fscanf(fd, "%h %h", a, b);
        if (r != 2) abort("malformed read record in the stimulus file");
        apb_read(a[3:0], b);
      end else if (op == "i") begin
        r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
        if (r != 4) abort("malformed issue record in the stimulus file");
        expect_issue(a[tag_w-1:0], b[tag_w-1:0], c[tag_w-1:0], d[0]);
      end else if (op == "n") begin
        r = $fscanf(fd, "%h %h", a, b);
        if (r != 2) abort("malformed idle record in the stimulus file");
        idle(int'(a), b[0]);
      end else begin
        abort("unknown record type in the stimulus file");
      end
    end
    $fclose(fd);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: src/issue_queue_top.sv
`timescale 1ns/1ps

module issue_queue_top #(
  parameter int DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [iq_pkg::addr_w-1:0] paddr,
  input  logic [iq_pkg::word_w-1:0] pwdata,
  output logic [iq_pkg::word_w-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      issue_valid,
  input  logic                      issue_ready,
  output logic [iq_pkg::tag_w-1:0]  issue_dst,
  output logic [iq_pkg::tag_w-1:0]  issue_src1,
  output logic [iq_pkg::tag_w-1:0]  issue_src2
);

  iq_ctrl_if #(.DEPTH(DEPTH)) ctrl ();   // allocate and wakeup bundle

  iq_apb_regs #(
    .DEPTH(DEPTH)
  ) i_regs (
    .clk    (clk),
    .rst    (rst),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .paddr  (paddr),
    .pwdata (pwdata),
    .prdata (prdata),
    .pready (pready),
    .pslverr(pslverr),
    .ctrl   (ctrl.regs)
  );

  iq_entry_store #(
    .DEPTH(DEPTH)
  ) i_store (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl.store),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue_dst  (issue_dst),
    .issue_src1 (issue_src1),
    .issue_src2 (issue_src2)
  );

endmodule

// File: src/iq_entry_store.sv
`timescale 1ns/1ps

module iq_entry_store #(
  parameter int DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  iq_ctrl_if.store                 ctrl,
  output logic                     issue_valid,
  input  logic                     issue_ready,
  output logic [iq_pkg::tag_w-1:0] issue_dst,
  output logic [iq_pkg::tag_w-1:0] issue_src1,
  output logic [iq_pkg::tag_w-1:0] issue_src2
);
  import iq_pkg::*;

  localparam int cnt_w = $clog2(DEPTH + 1);

  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] rdy1;
  logic [DEPTH-1:0] rdy2;
  logic [tag_w-1:0] dst_q  [DEPTH];
  logic [tag_w-1:0] src1_q [DEPTH];
  logic [tag_w-1:0] src2_q [DEPTH];
  logic [DEPTH-1:0] free;
  logic [DEPTH-1:0] alloc_idx;
  logic [DEPTH-1:0] req;
  logic [DEPTH-1:0] select;
  logic             issue_fire;
  logic [cnt_w-1:0] count_q;

  assign free      = ~valid;
  assign alloc_idx = free & (~free + DEPTH'(1));   // one-hot lowest free slot
  assign req       = valid & rdy1 & rdy2;

  age_matrix_select #(
    .DEPTH(DEPTH)
  ) i_age (
    .clk      (clk),
    .rst      (rst),
    .alloc_en (ctrl.alloc_en),
    .alloc_idx(alloc_idx),
    .req      (req),
    .select   (select)
  );

  assign issue_valid = |select;
  assign issue_fire  = issue_valid & issue_ready;

  // select is one-hot so an or-reduction acts as the mux
  always_comb begin
    issue_dst  = '0;
    issue_src1 = '0;
    issue_src2 = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (select[i]) begin
        issue_dst  = issue_dst | dst_q[i];
        issue_src1 = issue_src1 | src1_q[i];
        issue_src2 = issue_src2 | src2_q[i];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;
      rdy1  <= '0;
      rdy2  <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if (ctrl.alloc_en && alloc_idx[i]) begin
          valid[i] <= 1'b1;
          rdy1[i]  <= ctrl.alloc_word.src1_rdy;
          rdy2[i]  <= ctrl.alloc_word.src2_rdy;
        end else if (issue_fire && select[i]) begin
          valid[i] <= 1'b0;   // slot released on accepted issue
        end else if (ctrl.wake_en && valid[i]) begin
          // tag broadcast where both sources may match
          if (src1_q[i] == ctrl.wake_tag) rdy1[i] <= 1'b1;
          if (src2_q[i] == ctrl.wake_tag) rdy2[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (ctrl.alloc_en && alloc_idx[i]) begin
        dst_q[i]  <= ctrl.alloc_word.dst;
        src1_q[i] <= ctrl.alloc_word.src1;
        src2_q[i] <= ctrl.alloc_word.src2;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count_q <= '0;
    end else begin
      case ({ctrl.alloc_en, issue_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;   // both or neither
      endcase
    end
  end

  assign ctrl.count = count_q;
  assign ctrl.full  = (count_q == cnt_w'(DEPTH));

  // register block gating on full must keep a free slot available
  a_alloc_slot_free: assert property (
    @(posedge clk) disable iff (rst)
      ctrl.alloc_en |-> (alloc_idx != '0)
  ) else $error("allocation finds no free slot");

endmodule

// File: src/age_matrix_select.sv
`timescale 1ns/1ps

module age_matrix_select #(
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             alloc_en,
  input  logic [DEPTH-1:0] alloc_idx,   // one-hot
  input  logic [DEPTH-1:0] req,
  output logic [DEPTH-1:0] select
);

  logic [DEPTH-1:0][DEPTH-1:0] older;   // older[i][j] set when entry i is older than j
  logic [DEPTH-1:0][DEPTH-1:0] beats;

  // entry i wins when it is older than every other requester
  generate
    for (genvar i = 0; i < DEPTH; i++) begin : g_row
      for (genvar j = 0; j < DEPTH; j++) begin : g_col
        if (i == j) begin : g_diag
          assign beats[i][j] = 1'b1;
        end else begin : g_pair
          assign beats[i][j] = older[i][j] | ~req[j];
        end
      end
      assign select[i] = req[i] & (&beats[i]);
    end
  endgenerate

  // new entry becomes the youngest
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      older <= '0;
    end else if (alloc_en) begin
      for (int i = 0; i < DEPTH; i++) begin
        for (int j = 0; j < DEPTH; j++) begin
          older[i][j] <= ~alloc_idx[i] & (older[i][j] | alloc_idx[j]);
        end
      end
    end
  end

  // matrix stays a total order over live entries so exactly one winner exists
  a_select_onehot: assert property (
    @(posedge clk) disable iff (rst)
      $onehot0(select) && ((req == '0) || (select != '0))
  ) else $error("age select is not one-hot for a nonzero request vector");

endmodule

// File: src/iq_apb_regs.sv
`timescale 1ns/1ps

module iq_apb_regs #(
  parameter int DEPTH = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [iq_pkg::addr_w-1:0] paddr,
  input  logic [iq_pkg::word_w-1:0] pwdata,
  output logic [iq_pkg::word_w-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  iq_ctrl_if.regs                   ctrl
);
  import iq_pkg::*;

  localparam int cnt_w = $clog2(DEPTH + 1);

  iq_wdata_u         wdata;
  logic              setup;
  logic              access;
  logic              hit_enq;
  logic              hit_wake;
  logic              hit_status;
  logic              bad_addr;
  logic [word_w-1:0] status_word;

  assign wdata  = pwdata;
  assign setup  = psel & ~penable;
  assign access = psel & penable;   // zero wait states so the transfer ends here

  // enq and wake are write only and status is read only
  assign hit_enq    = pwrite & (paddr == addr_enq);
  assign hit_wake   = pwrite & (paddr == addr_wake);
  assign hit_status = ~pwrite & (paddr == addr_status);
  assign bad_addr   = ~(hit_enq | hit_wake | hit_status);

  assign ctrl.alloc_en   = access & hit_enq & ~ctrl.full;
  assign ctrl.alloc_word = wdata.enq;
  assign ctrl.wake_en    = access & hit_wake;
  assign ctrl.wake_tag   = wdata.wake.tag;

  assign pready  = 1'b1;
  assign pslverr = access & (bad_addr | (hit_enq & ctrl.full));

  always_comb begin
    status_word = '0;
    status_word[cnt_w-1:0] = ctrl.count;
    status_word[8] = ctrl.full;
  end

  // sampled in the setup phase so prdata is stable through the access phase
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prdata <= '0;
    end else if (setup && hit_status) begin
      prdata <= status_word;
    end
  end

  // a full queue must never see an allocation
  a_no_alloc_when_full: assert property (
    @(posedge clk) disable iff (rst) ctrl.alloc_en |-> (ctrl.count < cnt_w'(DEPTH))
  ) else $error("alloc_en raised while the queue is full");

endmodule

// File: src/iq_ctrl_if.sv
`timescale 1ns/1ps

interface iq_ctrl_if #(
  parameter int DEPTH = 8
);
  import iq_pkg::*;

  localparam int cnt_w = $clog2(DEPTH + 1);

  logic             alloc_en;    // one-cycle enqueue pulse
  iq_enq_t          alloc_word;
  logic             wake_en;     // one-cycle wakeup pulse
  logic [tag_w-1:0] wake_tag;
  logic [cnt_w-1:0] count;       // occupied slots
  logic             full;

  modport regs (
    output alloc_en,
    output alloc_word,
    output wake_en,
    output wake_tag,
    input  count,
    input  full
  );

  modport store (
    input  alloc_en,
    input  alloc_word,
    input  wake_en,
    input  wake_tag,
    output count,
    output full
  );

endinterface

// File: src/iq_pkg.sv
package iq_pkg;

  // physical register tag and host bus widths
  localparam int tag_w  = 6;
  localparam int word_w = 32;
  localparam int addr_w = 4;

  // apb byte addresses
  localparam logic [addr_w-1:0] addr_enq    = 4'h0;
  localparam logic [addr_w-1:0] addr_wake   = 4'h4;
  localparam logic [addr_w-1:0] addr_status = 4'h8;

  // enqueue view of a write word with the dst tag in the low bits
  typedef struct packed {
    logic [word_w-3*tag_w-3:0] unused;   // 12 spare bits
    logic                      src2_rdy;
    logic [tag_w-1:0]          src2;
    logic                      src1_rdy;
    logic [tag_w-1:0]          src1;
    logic [tag_w-1:0]          dst;
  } iq_enq_t;

  // wakeup view where only the broadcast tag is meaningful
  typedef struct packed {
    logic [word_w-tag_w-1:0] unused;
    logic [tag_w-1:0]        tag;
  } iq_wake_t;

  // same pwdata word decoded by register address
  typedef union packed {
    iq_enq_t  enq;
    iq_wake_t wake;
  } iq_wdata_u;

endpackage
